// File: rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int WORD_BITS   = 32;
	localparam int LINE_WORDS  = 4;
	localparam int INDEX_BITS  = 6;  // 64 lines.
	localparam int OFFSET_BITS = 2;  // Word within a line.
	localparam int TAG_BITS    = 22;

	typedef logic [WORD_BITS-1:0]                        word;
	typedef logic [TAG_BITS+INDEX_BITS+OFFSET_BITS-1:0] ptr;  // Word address.
	typedef logic [LINE_WORDS*WORD_BITS-1:0]             line;
	typedef logic [WORD_BITS/8-1:0]                      word_be;
	typedef logic [LINE_WORDS*WORD_BITS/8-1:0]           line_be;

	typedef logic [TAG_BITS-1:0]    addr_tag;
	typedef logic [INDEX_BITS-1:0]  addr_index;
	typedef logic [OFFSET_BITS-1:0] addr_offset;

	typedef union packed {
		ptr raw;
		struct packed {
			addr_tag    tag;
			addr_index  index;
			addr_offset offset;
		} fields;
	} addr_view;

endpackage

`default_nettype wire

// File: rtl/cache_state_pkg.sv
`default_nettype none

package cache_state_pkg;

	typedef enum logic [1:0] {
		INVALID,
		CLEAN,
		DIRTY  // Line differs from memory.
	} line_state;

	localparam logic [1:0] RESP_OKAY      = 2'd0;
	localparam logic [1:0] RESP_LOCK_FAIL = 2'd1;  // Store-conditional lost.

endpackage

`default_nettype wire

// File: rtl/cache_sweep.sv
`default_nettype none

module cache_sweep
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	output logic      sweep_busy,
	output addr_index sweep_index
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sweep_index <= '0;
			sweep_busy  <= 1'b1;
		end else if (sweep_busy) begin
			sweep_index <= sweep_index + 1'b1;  // Wraps to zero after the last line.
			if (sweep_index == '1)
				sweep_busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cache_control.sv
`default_nettype none

module cache_control
	import cache_pkg::*, cache_state_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       core_read,
	input  logic       core_write,
	input  logic       core_lock,
	input  logic       sweep_busy,
	input  logic       mem_waitrequest,
	input  addr_tag    tag_rd,
	input  addr_tag    core_tag,
	input  line_state  state_rd,
	input  logic       monitor_fail,
	output logic       core_waitrequest,
	output logic       mem_read,
	output logic       mem_write,
	output logic       write_data,
	output logic       write_state,
	output logic       data_wr_sel,
	output line_state  state_wr,
	output logic [1:0] core_response,
	output logic       monitor_acquire,
	output logic       monitor_commit,
	output logic       monitor_release,
	output logic       wb_select
);

	typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, FILL, REPLY} ctrl_state;

	ctrl_state state, state_next;
	logic hit, lock_write, lock_reject, done, write_hit, fill_done;

	assign hit         = state_rd != INVALID && tag_rd == core_tag;
	assign lock_write  = core_write && core_lock;
	assign lock_reject = lock_write && monitor_fail;  // Fails even on a miss.
	assign done        = state == LOOKUP && (hit || lock_reject);
	assign write_hit   = done && core_write && !lock_reject;
	assign fill_done   = state == FILL && !mem_waitrequest;

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		unique case (state)
			IDLE:      if ((core_read || core_write) && !sweep_busy) state_next = LOOKUP;
			LOOKUP:    if (done) state_next = IDLE;
			           else if (state_rd == DIRTY) state_next = WRITEBACK;
			           else state_next = FILL;
			WRITEBACK: if (!mem_waitrequest) state_next = FILL;
			FILL:      if (!mem_waitrequest) state_next = REPLY;
			REPLY:     state_next = LOOKUP;  // Filled line is read back here.
			default:   state_next = IDLE;
		endcase
	end

	assign core_waitrequest = !done;
	assign core_response    = lock_reject ? RESP_LOCK_FAIL : RESP_OKAY;

	assign mem_write = state == WRITEBACK;
	assign mem_read  = state == FILL;
	assign wb_select = state == WRITEBACK;  // Victim tag on the address.

	assign write_data  = write_hit || fill_done;
	assign data_wr_sel = write_hit;  // Core merge, else memory fill.
	assign write_state = sweep_busy || write_data;
	assign state_wr    = sweep_busy ? INVALID : (write_hit ? DIRTY : CLEAN);

	assign monitor_acquire = done && core_read && core_lock;
	assign monitor_commit  = done && lock_write;
	assign monitor_release = done && core_write && !core_lock;

endmodule

`default_nettype wire

// File: rtl/cache_sram.sv
`default_nettype none

module cache_sram
	import cache_pkg::*, cache_state_pkg::*;
(
	input  logic      clk,
	input  addr_index index_rd,
	input  addr_index index_wr,
	input  logic      write_data,
	input  logic      write_state,
	input  addr_tag   tag_wr,
	input  line_state state_wr,
	input  line       data_wr,
	output addr_tag   tag_rd,
	output line_state state_rd,
	output line       data_rd
);

	addr_tag   tag_mem   [2**INDEX_BITS];
	line_state state_mem [2**INDEX_BITS];
	line       data_mem  [2**INDEX_BITS];

	always_ff @(posedge clk) begin
		if (write_data) begin
			data_mem[index_wr] <= data_wr;
			tag_mem[index_wr]  <= tag_wr;
		end
		if (write_state)
			state_mem[index_wr] <= state_wr;  // Sweep writes only this.

		tag_rd   <= tag_mem[index_rd];  // Old contents on a same-cycle write.
		state_rd <= state_mem[index_rd];
		data_rd  <= data_mem[index_rd];
	end

endmodule

`default_nettype wire

// File: rtl/cache_routing.sv
`default_nettype none

module cache_routing
	import cache_pkg::*;
(
	input  ptr         core_address,
	input  addr_tag    tag_rd,
	input  line        data_rd,
	input  logic       wb_select,
	input  logic       sweep_busy,
	input  addr_index  sweep_index,
	output addr_index  index_rd,
	output addr_index  index_wr,
	output addr_tag    core_tag,
	output addr_offset core_offset,
	output word        core_readdata,
	output word        mem_address
);

	addr_view core_view, mem_view;

	assign core_view.raw = core_address;
	assign core_tag      = core_view.fields.tag;
	assign core_offset   = core_view.fields.offset;
	assign index_rd      = core_view.fields.index;
	assign index_wr      = sweep_busy ? sweep_index : core_view.fields.index;

	assign core_readdata = data_rd[core_offset * WORD_BITS +: WORD_BITS];

	always_comb begin
		mem_view.fields.tag    = wb_select ? tag_rd : core_view.fields.tag;
		mem_view.fields.index  = core_view.fields.index;
		mem_view.fields.offset = '0;  // Line base.
	end

	assign mem_address = {mem_view.raw, 2'b00};  // Byte address.

endmodule

`default_nettype wire

// File: rtl/cache_offsets.sv
`default_nettype none

module cache_offsets
	import cache_pkg::*;
(
	input  addr_offset core_offset,
	input  word        core_writedata,
	input  word_be     core_byteenable,
	input  line        data_rd,
	input  line        mem_readdata,
	input  logic       data_wr_sel,
	output line        data_wr,
	output line        mem_writedata,
	output line_be     mem_byteenable
);

	line    core_writedata_line, core_data_wr;
	line_be core_byteenable_line;

	// The word is copied into every lane; the enables pick the right one.
	assign core_writedata_line  = {LINE_WORDS{core_writedata}};
	assign core_byteenable_line = line_be'(core_byteenable) << (core_offset * (WORD_BITS / 8));

	always_comb begin
		for (int b = 0; b < LINE_WORDS * WORD_BITS / 8; b++)
			core_data_wr[b*8 +: 8] = core_byteenable_line[b] ?
				core_writedata_line[b*8 +: 8] : data_rd[b*8 +: 8];
	end

	assign data_wr        = data_wr_sel ? core_data_wr : mem_readdata;
	assign mem_writedata  = data_rd;  // Victim line.
	assign mem_byteenable = '1;

endmodule

`default_nettype wire

// File: rtl/cache_monitor.sv
`default_nettype none

module cache_monitor
	import cache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      monitor_acquire,
	input  logic      monitor_commit,
	input  logic      monitor_release,
	input  addr_tag   core_tag,
	input  addr_index index_rd,
	output logic      monitor_fail
);

	logic      res_valid, match;
	addr_tag   res_tag;
	addr_index res_index;

	assign match        = res_valid && res_tag == core_tag && res_index == index_rd;
	assign monitor_fail = !match;

	always_ff @(posedge clk) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else if (monitor_acquire)
			res_valid <= 1'b1;
		else if (monitor_commit || (monitor_release && match))
			res_valid <= 1'b0;  // Cleared whether the commit wins or not.
	end

	always_ff @(posedge clk) begin
		if (monitor_acquire) begin
			res_tag   <= core_tag;
			res_index <= index_rd;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cache.sv
`default_nettype none

module cache
	import cache_pkg::*, cache_state_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  ptr         core_address,
	input  logic       core_read,
	input  logic       core_write,
	input  logic       core_lock,
	input  word        core_writedata,
	input  word_be     core_byteenable,
	output logic       core_waitrequest,
	output logic [1:0] core_response,
	output word        core_readdata,

	input  logic       mem_waitrequest,
	input  line        mem_readdata,
	output word        mem_address,
	output logic       mem_read,
	output logic       mem_write,
	output line        mem_writedata,
	output line_be     mem_byteenable
);

	logic sweep_busy;
	addr_index sweep_index;

	logic write_data, write_state, data_wr_sel, wb_select;
	line_state state_wr, state_rd;
	addr_tag tag_rd, core_tag;
	addr_index index_rd, index_wr;
	addr_offset core_offset;
	line data_rd, data_wr;

	logic monitor_acquire, monitor_commit, monitor_release, monitor_fail;

	cache_sweep sweep (.*);

	cache_control control (.*);

	cache_sram sram
	(
		.tag_wr(core_tag),  // Tags only change on a fill.
		.*
	);

	cache_routing routing (.*);

	cache_offsets offsets (.*);

	cache_monitor monitor (.*);

endmodule

`default_nettype wire

// File: verification/cache_assert.sv
`default_nettype none

module cache_assert (
	input wire logic        clk,
	input wire logic        rst_n,
	input wire logic        mem_read,
	input wire logic        mem_write,
	input wire logic        mem_waitrequest,
	input wire logic [31:0] mem_address,
	input wire logic        core_waitrequest
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [6:0] since_reset;  // Cycles since rst_n rose, saturating at 64.

	always @(posedge clk) begin
		if (!rst_n)
			since_reset <= '0;
		else if (since_reset != 7'd64)
			since_reset <= since_reset + 7'd1;
	end

	strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write)) else $error("mem_read and mem_write both high");

	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_read && mem_waitrequest |=> mem_read && $stable(mem_address))
		else $error("Memory read dropped or address moved while stalled");

	write_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_write && mem_waitrequest |=> mem_write && $stable(mem_address))
		else $error("Memory write dropped or address moved while stalled");

	sweep_holds_core: assert property (@(posedge clk)
		rst_n && since_reset < 7'd64 |-> core_waitrequest)
		else $error("Core request accepted during the sweep");

endmodule

bind cache cache_assert port_checks (.*);

`default_nettype wire

// File: verification/cache_tb.sv
`default_nettype none

module cache_tb
	import cache_pkg::*, cache_state_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int REQUESTS   = 32 + 2 * 32 + 8 + 32 + 2 + 8 + 3 * 400;  // Most requests below.
	localparam int MISS_BOUND = 300;  // Worst-case cycles for one request.

	logic clk, rst_n;
	ptr core_address;
	logic core_read, core_write, core_lock, core_waitrequest;
	word core_writedata, core_readdata;
	word_be core_byteenable;
	logic [1:0] core_response;
	logic mem_waitrequest, mem_read, mem_write;
	line mem_readdata, mem_writedata;
	word mem_address;
	line_be mem_byteenable;

	int seed = 82512;
	int errors = 0;
	int checks = 0;
	string test_name = "reset";
	line mem_model [1024];
	word shadow [4096];
	logic res_valid = 1'b0;
	logic [27:0] res_line;

	cache UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word init_word(input int unsigned a);
		return (a * 32'h9E3779B1) ^ (a << 17) ^ 32'h5A5A_0F0F;
	endfunction

	// Returns {response, readdata} and updates the shadow and the reservation.
	function automatic logic [33:0] expect_read(input logic rd, input logic wr, input logic lk,
		input ptr a, input word d, input word_be be);
		logic [1:0] resp;
		word w;
		logic ok;
		resp = RESP_OKAY;
		w = shadow[a[11:0]];
		ok = 1'b1;
		if (rd && lk) begin
			res_valid = 1'b1;
			res_line  = a[29:2];
		end else if (wr) begin
			if (lk) begin
				ok = res_valid && res_line == a[29:2];
				res_valid = 1'b0;
				if (!ok)
					resp = RESP_LOCK_FAIL;
			end else if (res_line == a[29:2]) begin
				res_valid = 1'b0;
			end
			if (ok)
				for (int b = 0; b < 4; b++)
					if (be[b])
						w[b*8 +: 8] = d[b*8 +: 8];
			shadow[a[11:0]] = w;
		end
		return {resp, w};
	endfunction

	// Memory model with random stalls; readdata follows the address.
	assign mem_readdata = mem_model[mem_address[13:4]];

	always @(posedge clk) begin
		mem_waitrequest <= 1'($random(seed));
		if (mem_write && !mem_waitrequest) begin
			checks++;
			assert (mem_byteenable == 16'hFFFF) else begin
				errors++;
				$display("** Error %s byteenable: expected %h, actual %h", test_name,
					16'hFFFF, mem_byteenable);
			end
			for (int w = 0; w < LINE_WORDS; w++) begin
				checks++;
				assert (mem_writedata[w*32 +: 32] == shadow[{mem_address[13:4], 2'(w)}]) else begin
					errors++;
					$display("** Error %s writeback: expected %h, actual %h", test_name,
						shadow[{mem_address[13:4], 2'(w)}], mem_writedata[w*32 +: 32]);
				end
			end
			mem_model[mem_address[13:4]] <= mem_writedata;
		end
	end

	// Compare each completed request against the reference.
	always @(posedge clk) begin
		logic [33:0] exp;
		if (rst_n && (core_read || core_write) && !core_waitrequest) begin
			exp = expect_read(core_read, core_write, core_lock, core_address,
				core_writedata, core_byteenable);
			checks++;
			assert (core_response == exp[33:32]) else begin
				errors++;
				$display("** Error %s response: expected %0d, actual %0d", test_name,
					exp[33:32], core_response);
			end
			if (core_read) begin
				assert (core_readdata == exp[31:0]) else begin
					errors++;
					$display("** Error %s readdata @%h: expected %h, actual %h", test_name,
						core_address, exp[31:0], core_readdata);
				end
			end
		end
	end

	task automatic run_request(input logic rd, input logic wr, input logic lk, input ptr a,
		input word d, input word_be be, output int cycles, output logic saw_fill);
		@(posedge clk);
		core_read <= rd;
		core_write <= wr;
		core_lock <= lk;
		core_address <= a;
		core_writedata <= d;
		core_byteenable <= be;
		cycles = 0;
		saw_fill = 1'b0;
		forever begin
			@(posedge clk);
			cycles++;
			if (mem_read)
				saw_fill = 1'b1;
			if (!core_waitrequest)
				break;
		end
		core_read <= 1'b0;
		core_write <= 1'b0;
		core_lock <= 1'b0;
	endtask

	task automatic read_word(input ptr a, input logic lk);
		int c;
		logic f;
		run_request(1'b1, 1'b0, lk, a, '0, '0, c, f);
	endtask

	task automatic write_word(input ptr a, input word d, input word_be be, input logic lk);
		int c;
		logic f;
		run_request(1'b0, 1'b1, lk, a, d, be, c, f);
	endtask

	initial begin
		#((REQUESTS * MISS_BOUND + 200) * 20);
		$display("Watchdog: simulation ran out of time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int cycles;
		logic saw_fill;
		ptr a;
		for (int i = 0; i < 4096; i++)
			shadow[i] = init_word(i);
		for (int l = 0; l < 1024; l++)
			for (int w = 0; w < LINE_WORDS; w++)
				mem_model[l][w*32 +: 32] = init_word(l * 4 + w);
		rst_n = 1'b0;
		core_read = 1'b0;
		core_write = 1'b0;
		core_lock = 1'b0;
		core_address = '0;
		core_writedata = '0;
		core_byteenable = '0;
		mem_waitrequest = 1'b1;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "initial_read";
		for (int i = 0; i < 32; i++)
			read_word(ptr'((i * 131) % 4096), 1'b0);

		test_name = "byte_write";
		for (int i = 0; i < 32; i++) begin
			a = ptr'($random(seed) & 12'hFFF);
			write_word(a, $random(seed), 4'($random(seed)), 1'b0);
			read_word(a, 1'b0);
		end

		test_name = "alias";  // Index 5 under eight tags.
		for (int t = 0; t < 8; t++)
			write_word(ptr'((t << 8) | (5 << 2) | (t & 3)), $random(seed), 4'hF, 1'b0);
		for (int t = 0; t < 8; t++)
			for (int w = 0; w < 4; w++)
				read_word(ptr'((t << 8) | (5 << 2) | w), 1'b0);

		test_name = "hit_latency";
		read_word(ptr'(12'h0A4), 1'b0);
		run_request(1'b1, 1'b0, 1'b0, ptr'(12'h0A4), '0, '0, cycles, saw_fill);
		checks++;
		assert (cycles == 2 && !saw_fill) else begin
			errors++;
			$display("** Error %s: expected 2 cycles, actual %0d (fill seen %0b)",
				test_name, cycles, saw_fill);
		end

		test_name = "lock";
		read_word(ptr'(12'h230), 1'b1);
		write_word(ptr'(12'h230), 32'hCAFE_F00D, 4'hF, 1'b1);
		read_word(ptr'(12'h230), 1'b0);
		write_word(ptr'(12'h230), 32'h1111_2222, 4'hF, 1'b1);
		read_word(ptr'(12'h230), 1'b1);
		write_word(ptr'(12'h231), 32'h3333_4444, 4'h3, 1'b0);
		write_word(ptr'(12'h230), 32'h5555_6666, 4'hF, 1'b1);
		read_word(ptr'(12'h230), 1'b0);

		test_name = "random_mix";
		for (int i = 0; i < 400; i++) begin
			a = ptr'($random(seed) & 12'h71F);
			if ($random(seed) & 1)
				read_word(a, 1'b0);
			if (($random(seed) & 3) == 0)
				read_word(a, 1'b1);
			write_word(a, $random(seed), 4'($random(seed)), (($random(seed) & 3) == 0));
		end

		repeat (4) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
rtl/cache_pkg.sv
rtl/cache_state_pkg.sv
rtl/cache_sweep.sv
rtl/cache_control.sv
rtl/cache_sram.sv
rtl/cache_routing.sv
rtl/cache_offsets.sv
rtl/cache_monitor.sv
rtl/cache.sv
verification/cache_assert.sv
verification/cache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cache_tb -f project.f -o cache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error"
fi

cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1
